//--- Bender.yml
package:
  name: tpu_ctrl

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/tpu_ctrl_pkg.sv
      - design/cmd_fifo.sv
      - design/weight_loader.sv
      - design/operand_streamer.sv
      - design/writeback_tracker.sv
      - design/tpu_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tpu_ctrl_tb.sv

//--- design/cmd_fifo.sv
`timescale 1ns/1ps
`include "tpu_ctrl_defs.svh"

module cmd_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_valid,
    input  logic [`TPU_CMD_WIDTH-1:0] cmd_data,
    output logic                      cmd_ready,
    output logic [`TPU_CMD_WIDTH-1:0] head,
    output logic                      head_valid,
    input  logic                      pop
);

    localparam int DEPTH = `TPU_CMD_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`TPU_CMD_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      push;
    logic                      take;

    assign cmd_ready  = (count != CNT_W'(DEPTH));
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    assign push = cmd_valid && cmd_ready;
    assign take = pop && head_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count as is
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_data;
        end
    end

endmodule

//--- design/operand_streamer.sv
`timescale 1ns/1ps
`include "tpu_ctrl_defs.svh"

module operand_streamer
    import tpu_ctrl_pkg::*;
#(
    parameter int FWD_WIDTH = 2 * `TPU_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [`TPU_ADDR_WIDTH-1:0] base,
    input  logic [FWD_WIDTH-1:0]       fwd_in,
    output logic                       rd_en,
    output logic [`TPU_ADDR_WIDTH-1:0] rd_addr,
    output logic                       valid,
    output logic                       burst_start,
    output logic                       done,
    output logic [FWD_WIDTH-1:0]       fwd_out,
    output logic                       busy
);

    localparam int W     = `TPU_ARRAY_W;
    localparam int CNT_W = `TPU_IDX_WIDTH;

    burst_state_e     state;
    logic [CNT_W-1:0] cnt;
    logic             accept;

    // a start is taken while idle or in the gap after a burst
    assign accept = start && (state != burst_reading);
    assign busy   = (state != burst_idle);

    // =========================================================================
    // burst control
    // =========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= burst_idle;
            cnt         <= '0;
            rd_en       <= 1'b0;
            valid       <= 1'b0;
            burst_start <= 1'b0;
            done        <= 1'b0;
        end else begin
            burst_start <= 1'b0;
            done        <= 1'b0;
            valid       <= rd_en;
            case (state)
                burst_idle, burst_gap: begin
                    if (accept) begin
                        rd_en       <= 1'b1;
                        burst_start <= 1'b1;
                        cnt         <= '0;
                        state       <= burst_reading;
                    end else begin
                        state <= burst_idle;
                    end
                end
                burst_reading: begin
                    if (cnt == CNT_W'(W - 1)) begin
                        rd_en <= 1'b0;
                        done  <= 1'b1;
                        state <= burst_gap;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= burst_idle;
            endcase
        end
    end

    // read address and the field passed to the next stage
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_addr <= base;
            fwd_out <= fwd_in;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

endmodule

//--- design/tpu_ctrl_defs.svh
`ifndef TPU_CTRL_DEFS_SVH
`define TPU_CTRL_DEFS_SVH

// =========================================================================
// systolic array geometry
// =========================================================================

// reads per burst and rows per writeback
`define TPU_ARRAY_W     16

// buffer address width
`define TPU_ADDR_WIDTH  10

// =========================================================================
// host command and queue sizing
// =========================================================================

`define TPU_CMD_WIDTH   64
`define TPU_CMD_DEPTH   4

// also the number of writeback credits held by the weight loader
`define TPU_WB_DEPTH    4

`define TPU_IDX_WIDTH   $clog2(`TPU_ARRAY_W)

`endif

//--- design/tpu_ctrl_pkg.sv
`include "tpu_ctrl_defs.svh"

package tpu_ctrl_pkg;

    // host command word, msb first
    // low bits once carried the m/k/n lengths, now reserved
    typedef struct packed {
        logic [`TPU_ADDR_WIDTH-1:0]                    addr_d;
        logic [`TPU_ADDR_WIDTH-1:0]                    addr_c;
        logic [`TPU_ADDR_WIDTH-1:0]                    addr_b;
        logic [`TPU_ADDR_WIDTH-1:0]                    addr_a;
        logic [`TPU_CMD_WIDTH-4*`TPU_ADDR_WIDTH-1:0] rsvd;
    } command_t;

    // read burst stages (weight loader and operand streamers)
    typedef enum logic [1:0] {
        burst_idle,
        burst_reading,
        burst_gap
    } burst_state_e;

    // writeback tracker
    typedef enum logic {
        wb_idle,
        wb_writing
    } wb_state_e;

endpackage

//--- design/tpu_ctrl_top.sv
`timescale 1ns/1ps
`include "tpu_ctrl_defs.svh"

module tpu_ctrl_top
    import tpu_ctrl_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  logic [`TPU_CMD_WIDTH-1:0]  cmd_data,
    output logic                       cmd_ready,
    output logic                       busy,
    output logic                       done_irq,
    output logic [`TPU_ADDR_WIDTH-1:0] ctrl_rd_addr_a,
    output logic                       ctrl_rd_en_a,
    output logic                       ctrl_a_valid,
    output logic                       ctrl_a_switch,
    output logic [`TPU_ADDR_WIDTH-1:0] ctrl_rd_addr_b,
    output logic                       ctrl_rd_en_b,
    output logic                       ctrl_b_accept_w,
    output logic [`TPU_IDX_WIDTH-1:0]  ctrl_b_weight_index,
    output logic [`TPU_ADDR_WIDTH-1:0] ctrl_rd_addr_c,
    output logic                       ctrl_rd_en_c,
    output logic                       ctrl_c_valid,
    input  logic                       core_writeback_valid,
    output logic [`TPU_ADDR_WIDTH-1:0] ctrl_wr_addr_d
);

    localparam int AW = `TPU_ADDR_WIDTH;

    command_t              fifo_head;
    logic                  head_valid;
    logic                  pop;
    logic                  a_start;
    logic [AW-1:0]         a_base;
    logic [2*AW-1:0]       a_fwd;
    logic                  act_done;
    logic [2*AW-1:0]       act_fwd;
    logic                  bias_done;
    logic [AW-1:0]         bias_addr_d;
    logic                  wl_busy;
    logic                  act_busy;
    logic                  bias_busy;
    logic                  wb_busy;

    assign busy = head_valid || wl_busy || act_busy || bias_busy || wb_busy;

    cmd_fifo u_cmd_fifo (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_data   (cmd_data),
        .cmd_ready  (cmd_ready),
        .head       (fifo_head),
        .head_valid (head_valid),
        .pop        (pop)
    );

    // done_irq returns a writeback credit
    weight_loader u_weight_loader (
        .clk                 (clk),
        .rst                 (rst),
        .head                (fifo_head),
        .head_valid          (head_valid),
        .pop                 (pop),
        .task_done           (done_irq),
        .ctrl_rd_en_b        (ctrl_rd_en_b),
        .ctrl_rd_addr_b      (ctrl_rd_addr_b),
        .ctrl_b_accept_w     (ctrl_b_accept_w),
        .ctrl_b_weight_index (ctrl_b_weight_index),
        .a_start             (a_start),
        .a_base              (a_base),
        .a_fwd               (a_fwd),
        .busy                (wl_busy)
    );

    // activation stage carries {addr_c, addr_d} forward
    operand_streamer #(.FWD_WIDTH(2 * AW)) act_stream (
        .clk         (clk),
        .rst         (rst),
        .start       (a_start),
        .base        (a_base),
        .fwd_in      (a_fwd),
        .rd_en       (ctrl_rd_en_a),
        .rd_addr     (ctrl_rd_addr_a),
        .valid       (ctrl_a_valid),
        .burst_start (ctrl_a_switch),
        .done        (act_done),
        .fwd_out     (act_fwd),
        .busy        (act_busy)
    );

    operand_streamer #(.FWD_WIDTH(AW)) bias_stream (
        .clk         (clk),
        .rst         (rst),
        .start       (act_done),
        .base        (act_fwd[2*AW-1:AW]),
        .fwd_in      (act_fwd[AW-1:0]),
        .rd_en       (ctrl_rd_en_c),
        .rd_addr     (ctrl_rd_addr_c),
        .valid       (ctrl_c_valid),
        .burst_start (),
        .done        (bias_done),
        .fwd_out     (bias_addr_d),
        .busy        (bias_busy)
    );

    writeback_tracker u_writeback_tracker (
        .clk                  (clk),
        .rst                  (rst),
        .push                 (bias_done),
        .push_addr            (bias_addr_d),
        .core_writeback_valid (core_writeback_valid),
        .ctrl_wr_addr_d       (ctrl_wr_addr_d),
        .done_irq             (done_irq),
        .busy                 (wb_busy)
    );

endmodule

//--- design/weight_loader.sv
`timescale 1ns/1ps
`include "tpu_ctrl_defs.svh"

module weight_loader
    import tpu_ctrl_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  command_t                      head,
    input  logic                          head_valid,
    output logic                          pop,
    input  logic                          task_done,
    output logic                          ctrl_rd_en_b,
    output logic [`TPU_ADDR_WIDTH-1:0]    ctrl_rd_addr_b,
    output logic                          ctrl_b_accept_w,
    output logic [`TPU_IDX_WIDTH-1:0]     ctrl_b_weight_index,
    output logic                          a_start,
    output logic [`TPU_ADDR_WIDTH-1:0]    a_base,
    output logic [2*`TPU_ADDR_WIDTH-1:0]  a_fwd,
    output logic                          busy
);

    localparam int W     = `TPU_ARRAY_W;
    localparam int IDX_W = `TPU_IDX_WIDTH;
    localparam int CRD_W = $clog2(`TPU_WB_DEPTH + 1);

    burst_state_e     state;
    logic [IDX_W-1:0] cnt;
    logic [CRD_W-1:0] credits;
    logic             can_pop;

    // a new command needs a free writeback slot
    assign can_pop = head_valid && (credits != '0);
    assign busy    = (state != burst_idle);

    // =========================================================================
    // burst control
    // =========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= burst_idle;
            cnt             <= '0;
            pop             <= 1'b0;
            a_start         <= 1'b0;
            ctrl_rd_en_b    <= 1'b0;
            ctrl_b_accept_w <= 1'b0;
        end else begin
            pop             <= 1'b0;
            a_start         <= 1'b0;
            ctrl_b_accept_w <= ctrl_rd_en_b;
            case (state)
                burst_idle: begin
                    if (can_pop) begin
                        pop   <= 1'b1;
                        state <= burst_gap;
                    end
                end
                burst_reading: begin
                    if (cnt == IDX_W'(W - 1)) begin
                        // last read, hand off and try the next command
                        ctrl_rd_en_b <= 1'b0;
                        a_start      <= 1'b1;
                        pop          <= can_pop;
                        state        <= burst_gap;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                burst_gap: begin
                    // pop high here means a command was just taken
                    if (pop) begin
                        ctrl_rd_en_b <= 1'b1;
                        cnt          <= '0;
                        state        <= burst_reading;
                    end else begin
                        state <= burst_idle;
                    end
                end
                default: state <= burst_idle;
            endcase
        end
    end

    // credits: spent on pop, returned on task completion
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRD_W'(`TPU_WB_DEPTH);
        end else begin
            case ({pop, task_done})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // addresses and forwarded fields
    always_ff @(posedge clk) begin
        if (pop) begin
            ctrl_rd_addr_b <= head.addr_b;
            a_base         <= head.addr_a;
            a_fwd          <= {head.addr_c, head.addr_d};
        end else if (ctrl_rd_en_b) begin
            ctrl_rd_addr_b <= ctrl_rd_addr_b + 1'b1;
        end
        // index runs down, one cycle behind the read
        if (ctrl_rd_en_b) begin
            ctrl_b_weight_index <= IDX_W'(W - 1) - cnt;
        end
    end

endmodule

//--- design/writeback_tracker.sv
`timescale 1ns/1ps
`include "tpu_ctrl_defs.svh"

module writeback_tracker
    import tpu_ctrl_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic [`TPU_ADDR_WIDTH-1:0] push_addr,
    input  logic                       core_writeback_valid,
    output logic [`TPU_ADDR_WIDTH-1:0] ctrl_wr_addr_d,
    output logic                       done_irq,
    output logic                       busy
);

    localparam int W     = `TPU_ARRAY_W;
    localparam int DEPTH = `TPU_WB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int ROW_W = `TPU_IDX_WIDTH;

    logic [`TPU_ADDR_WIDTH-1:0] addr_q [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic [ROW_W-1:0]           row;
    wb_state_e                  state;
    logic                       take;

    // start the next task once idle with a queued address
    assign take = (state == wb_idle) && (count != '0);
    assign busy = (count != '0) || (state == wb_writing);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            row      <= '0;
            state    <= wb_idle;
            done_irq <= 1'b0;
        end else begin
            done_irq <= 1'b0;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case (state)
                wb_idle: begin
                    if (take) begin
                        row   <= '0;
                        state <= wb_writing;
                    end
                end
                wb_writing: begin
                    if (core_writeback_valid) begin
                        if (row == ROW_W'(W - 1)) begin
                            done_irq <= 1'b1;
                            state    <= wb_idle;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end
                end
                default: state <= wb_idle;
            endcase
        end
    end

    // address queue and the running writeback address
    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= push_addr;
        end
        if (take) begin
            ctrl_wr_addr_d <= addr_q[rd_ptr];
        end else if ((state == wb_writing) && core_writeback_valid) begin
            ctrl_wr_addr_d <= ctrl_wr_addr_d + 1'b1;
        end
    end

endmodule

//--- dv/tpu_ctrl_tb.sv
`timescale 1ns/1ps
`include "tpu_ctrl_defs.svh"

module tpu_ctrl_tb
    import tpu_ctrl_pkg::*;
();

    localparam int W     = `TPU_ARRAY_W;
    localparam int AW    = `TPU_ADDR_WIDTH;
    localparam int NUM   = 14;
    localparam int LIMIT = (NUM + 4) * (3 * W + 8) * 2;

    typedef struct packed {
        logic          hold;
        logic [AW-1:0] addr_d;
        logic [AW-1:0] addr_c;
        logic [AW-1:0] addr_b;
        logic [AW-1:0] addr_a;
    } entry_t;

    // hold, addr_d, addr_c, addr_b, addr_a
    // held group is long enough to fill credits and the command queue
    entry_t tbl [NUM] = '{
        {1'b0, 10'h300, 10'h200, 10'h100, 10'h000},
        {1'b0, 10'h310, 10'h210, 10'h110, 10'h010},
        {1'b0, 10'h2f8, 10'h1f8, 10'h0f0, 10'h3f8},
        {1'b1, 10'h340, 10'h240, 10'h140, 10'h040},
        {1'b1, 10'h350, 10'h250, 10'h150, 10'h050},
        {1'b1, 10'h360, 10'h260, 10'h160, 10'h060},
        {1'b1, 10'h370, 10'h270, 10'h170, 10'h070},
        {1'b1, 10'h380, 10'h280, 10'h180, 10'h080},
        {1'b1, 10'h390, 10'h290, 10'h190, 10'h090},
        {1'b1, 10'h3a0, 10'h2a0, 10'h1a0, 10'h0a0},
        {1'b1, 10'h3b0, 10'h2b0, 10'h1b0, 10'h0b0},
        {1'b1, 10'h3c0, 10'h2c0, 10'h1c0, 10'h0c0},
        {1'b0, 10'h3fc, 10'h2f0, 10'h3f4, 10'h1e0},
        {1'b0, 10'h3d0, 10'h2d0, 10'h1d0, 10'h0d0}
    };

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    command_t          cmd_data;
    logic              cmd_ready;
    logic              busy;
    logic              done_irq;
    logic [AW-1:0]     ctrl_rd_addr_a;
    logic              ctrl_rd_en_a;
    logic              ctrl_a_valid;
    logic              ctrl_a_switch;
    logic [AW-1:0]     ctrl_rd_addr_b;
    logic              ctrl_rd_en_b;
    logic              ctrl_b_accept_w;
    logic [`TPU_IDX_WIDTH-1:0] ctrl_b_weight_index;
    logic [AW-1:0]     ctrl_rd_addr_c;
    logic              ctrl_rd_en_c;
    logic              ctrl_c_valid;
    logic              core_writeback_valid;
    logic [AW-1:0]     ctrl_wr_addr_d;

    // scoreboards filled as commands are accepted
    logic [AW-1:0] exp_a [$];
    logic [AW-1:0] exp_b [$];
    logic [AW-1:0] exp_c [$];
    logic [AW-1:0] exp_d [$];
    logic [AW-1:0] pend_addr [$];
    int            pend_ready [$];

    logic [AW-1:0] base_a;
    logic [AW-1:0] base_b;
    logic [AW-1:0] base_c;
    logic [AW-1:0] wb_base;
    int            cnt_a = 0;
    int            cnt_b = 0;
    int            cnt_c = 0;
    int            cnt_idx = 0;
    int            wb_row = 0;
    int            cyc = 0;
    int            done_due = -1;
    int            done_count = 0;
    int            bursts = 0;
    int            bursts_at_hold = 0;
    int            stall_cycles = 0;
    bit            wb_active = 0;
    bit            hold_wb = 0;
    bit            hold_group = 0;
    bit            stall_seen = 0;
    logic          prev_en_a = 1'b0;
    logic          prev_en_b = 1'b0;
    logic          prev_en_c = 1'b0;
    logic [31:0]   rnd_state = 32'hd782;
    logic          wb_next;

    tpu_ctrl_top uut (
        .clk                  (clk),
        .rst                  (rst),
        .cmd_valid            (cmd_valid),
        .cmd_data             (cmd_data),
        .cmd_ready            (cmd_ready),
        .busy                 (busy),
        .done_irq             (done_irq),
        .ctrl_rd_addr_a       (ctrl_rd_addr_a),
        .ctrl_rd_en_a         (ctrl_rd_en_a),
        .ctrl_a_valid         (ctrl_a_valid),
        .ctrl_a_switch        (ctrl_a_switch),
        .ctrl_rd_addr_b       (ctrl_rd_addr_b),
        .ctrl_rd_en_b         (ctrl_rd_en_b),
        .ctrl_b_accept_w      (ctrl_b_accept_w),
        .ctrl_b_weight_index  (ctrl_b_weight_index),
        .ctrl_rd_addr_c       (ctrl_rd_addr_c),
        .ctrl_rd_en_c         (ctrl_rd_en_c),
        .ctrl_c_valid         (ctrl_c_valid),
        .core_writeback_valid (core_writeback_valid),
        .ctrl_wr_addr_d       (ctrl_wr_addr_d)
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // writeback valid about 70 percent of cycles and low while held
    always @(posedge clk) begin
        rnd_state = xorshift(rnd_state);
        wb_next   = !hold_wb && (rnd_state % 100 < 70);
        #1;
        core_writeback_valid = wb_next;
    end

    // ========================================================================
    // monitors sampled at the falling edge
    // ========================================================================
    always @(negedge clk) begin
        if (!rst) begin
            cyc++;
            if (cyc > LIMIT) begin
                stop_run($sformatf("timeout: %0d cycles passed, only %0d of %0d commands done",
                                   cyc, done_count, NUM));
            end
            if (cmd_valid && cmd_ready) begin
                exp_a.push_back(cmd_data.addr_a);
                exp_b.push_back(cmd_data.addr_b);
                exp_c.push_back(cmd_data.addr_c);
                exp_d.push_back(cmd_data.addr_d);
            end

            // weight port
            check_value("weight accept", prev_en_b, ctrl_b_accept_w);
            if (ctrl_rd_en_b) begin
                if (cnt_b == 0) begin
                    if (exp_b.size() == 0) begin
                        stop_run("weight read started with no command accepted");
                    end else begin
                        base_b = exp_b.pop_front();
                        bursts++;
                    end
                    if (hold_wb) begin
                        check_value("weight bursts while held", 1,
                                    bursts - bursts_at_hold <= `TPU_WB_DEPTH);
                    end
                end
                check_value("weight address", AW'(base_b + cnt_b), ctrl_rd_addr_b);
                cnt_b = (cnt_b + 1) % W;
            end else if (cnt_b != 0) begin
                stop_run("weight read burst ended before all reads were issued");
            end
            if (ctrl_b_accept_w) begin
                check_value("weight index", W - 1 - cnt_idx, ctrl_b_weight_index);
                cnt_idx = (cnt_idx + 1) % W;
            end

            // activation port
            check_value("activation valid", prev_en_a, ctrl_a_valid);
            check_value("activation switch", ctrl_rd_en_a && (cnt_a == 0), ctrl_a_switch);
            if (ctrl_rd_en_a) begin
                if (cnt_a == 0) begin
                    if (exp_a.size() == 0) begin
                        stop_run("activation read started with no command accepted");
                    end else begin
                        base_a = exp_a.pop_front();
                    end
                end
                check_value("activation address", AW'(base_a + cnt_a), ctrl_rd_addr_a);
                cnt_a = (cnt_a + 1) % W;
            end else if (cnt_a != 0) begin
                stop_run("activation read burst ended before all reads were issued");
            end

            // bias port
            // the last read queues the writeback task
            check_value("bias valid", prev_en_c, ctrl_c_valid);
            if (ctrl_rd_en_c) begin
                if (cnt_c == 0) begin
                    if (exp_c.size() == 0) begin
                        stop_run("bias read started with no command accepted");
                    end else begin
                        base_c = exp_c.pop_front();
                    end
                end
                check_value("bias address", AW'(base_c + cnt_c), ctrl_rd_addr_c);
                if (cnt_c == W - 1) begin
                    pend_addr.push_back(exp_d.pop_front());
                    pend_ready.push_back(cyc + 2);
                end
                cnt_c = (cnt_c + 1) % W;
            end else if (cnt_c != 0) begin
                stop_run("bias read burst ended before all reads were issued");
            end

            // writeback
            check_value("done_irq", cyc == done_due, done_irq);
            if (done_irq) begin
                done_count++;
            end
            if (wb_active) begin
                if (core_writeback_valid) begin
                    check_value("writeback address", AW'(wb_base + wb_row), ctrl_wr_addr_d);
                    wb_row++;
                    if (wb_row == W) begin
                        wb_active = 0;
                        done_due  = cyc + 1;
                    end
                end
            end else if (pend_ready.size() > 0 && pend_ready[0] <= cyc) begin
                wb_base = pend_addr.pop_front();
                void'(pend_ready.pop_front());
                wb_row    = 0;
                wb_active = 1;
            end

            // release the hold once the stall has lasted two burst periods
            if (hold_wb && cmd_valid && !cmd_ready
                    && (bursts - bursts_at_hold == `TPU_WB_DEPTH)) begin
                stall_cycles++;
                if (stall_cycles == 2 * (W + 1)) begin
                    stall_seen = 1;
                    hold_wb    = 0;
                end
            end
            prev_en_a = ctrl_rd_en_a;
            prev_en_b = ctrl_rd_en_b;
            prev_en_c = ctrl_rd_en_c;
        end
    end

    task automatic wait_idle();
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // data stays put until the transfer
    task automatic push_entry(input entry_t e);
        cmd_data.addr_a = e.addr_a;
        cmd_data.addr_b = e.addr_b;
        cmd_data.addr_c = e.addr_c;
        cmd_data.addr_d = e.addr_d;
        cmd_data.rsvd   = '0;
        cmd_valid       = 1'b1;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin
        rst                  = 1'b1;
        cmd_valid            = 1'b0;
        cmd_data             = '0;
        core_writeback_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("outputs after reset", 0,
                    {ctrl_rd_en_a, ctrl_a_valid, ctrl_a_switch, ctrl_rd_en_b,
                     ctrl_b_accept_w, ctrl_rd_en_c, ctrl_c_valid, done_irq, busy});
        check_value("cmd_ready after reset", 1, cmd_ready);
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM; i++) begin
            if (tbl[i].hold && !hold_group) begin
                // start the held group from an idle DUT with all credits
                cmd_valid = 1'b0;
                wait_idle();
                hold_wb        = 1;
                bursts_at_hold = bursts;
            end
            hold_group = tbl[i].hold;
            push_entry(tbl[i]);
        end
        cmd_valid = 1'b0;

        while (done_count < NUM) @(posedge clk);
        @(negedge clk);
        check_value("busy after drain", 0, busy);
        check_value("outstanding commands", 0,
                    exp_a.size() + exp_b.size() + exp_c.size() + exp_d.size()
                    + pend_addr.size());
        check_value("back-pressure stall", 1, stall_seen);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+design
design/tpu_ctrl_pkg.sv
design/cmd_fifo.sv
design/weight_loader.sv
design/operand_streamer.sv
design/writeback_tracker.sv
design/tpu_ctrl_top.sv
dv/tpu_ctrl_tb.sv
